/* bench/tb_encode.svh */
// rv32i instruction encoders for the integer pipeline testbench
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

localparam logic [6:0] OPC_REG_T   = 7'b0110011;
localparam logic [6:0] OPC_IMM_T   = 7'b0010011;
localparam logic [6:0] OPC_LUI_T   = 7'b0110111;
localparam logic [6:0] OPC_AUIPC_T = 7'b0010111;

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_REG_T};
endfunction

function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_IMM_T};
endfunction

// shamt sits where rs2 would be, funct7 picks logical or arithmetic
function automatic logic [31:0] shift_imm(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] shamt);
    return {f7, shamt, rs1, f3, rd, OPC_IMM_T};
endfunction

function automatic logic [31:0] upper_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

`endif

/* bench/int_pipe_tb.sv */
// testbench for the rv32i integer pipeline with a register model and writeback checks
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module int_pipe_tb;

    `include "tb_encode.svh"

    localparam int RESET_CYCLES = 16;
    // issued cycles per test including bubbles
    localparam int T1_CYCLES = 35;
    localparam int T2_CYCLES = 315;
    localparam int T3_CYCLES = 88;
    localparam int T4_CYCLES = 36;
    localparam int T5_CYCLES = 16;
    localparam int T6_CYCLES = 40;
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES + T6_CYCLES + NUM_TESTS * (2 + 50);

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
        logic [31:0]        tick;    // drive cycle of the instruction
    } wb_exp_s;

    logic                 clk_i;
    logic                 rst_i;
    logic [`XLEN-1:0]     instr_i;
    logic                 instr_valid_i;
    logic [`XLEN-1:0]     pc_i;
    logic                 wb_valid_o;
    logic [`REG_AW-1:0]   wb_rd_o;
    logic [`XLEN-1:0]     wb_data_o;

    logic [`XLEN-1:0] model_regs [0:`REG_COUNT-1];
    wb_exp_s          exp_q [$];
    logic [31:0]      tick;
    logic [`XLEN-1:0] cur_pc;
    int               errors;
    int               tests_passed;
    int               tests_failed;
    int               cycles;

    int_pipe_top dut0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // rv32i alu semantics where alt selects sub and sra
    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] res;
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // {funct3, alt} of the ten register operations
    function automatic logic [3:0] r_op(input int k);
        case (k)
            0: return 4'b0000;    // add
            1: return 4'b0001;    // sub
            2: return 4'b0010;    // sll
            3: return 4'b0100;    // slt
            4: return 4'b0110;    // sltu
            5: return 4'b1000;    // xor
            6: return 4'b1010;    // srl
            7: return 4'b1011;    // sra
            8: return 4'b1100;    // or
            default: return 4'b1110;
        endcase
    endfunction

    function automatic logic pending_valid();
        logic any;
        any = 1'b0;
        foreach (exp_q[i]) begin
            if (exp_q[i].valid) any = 1'b1;
        end
        return any;
    endfunction

    // an entry is due two drive cycles after issue and the outputs stay idle otherwise
    task automatic check_outputs();
        wb_exp_s e;
        if (exp_q.size() > 0 && exp_q[0].tick + 32'd2 == tick) begin
            e = exp_q.pop_front();
            assert (wb_valid_o == e.valid) else begin
                $display("mismatch wb_valid_o: got %h expected %h", wb_valid_o, e.valid);
                errors++;
            end
            if (e.valid && wb_valid_o) begin
                assert (wb_rd_o == e.rd) else begin
                    $display("mismatch wb_rd_o: got %h expected %h", wb_rd_o, e.rd);
                    errors++;
                end
                assert (wb_data_o == e.data) else begin
                    $display("mismatch wb_data_o: got %h expected %h", wb_data_o, e.data);
                    errors++;
                end
            end
        end else begin
            assert (!wb_valid_o) else begin
                $display("writeback to x%0d with no instruction outstanding", wb_rd_o);
                errors++;
            end
        end
    endtask

    task automatic drive(input logic v, input logic [31:0] instr, input logic exp_v,
                         input logic [`REG_AW-1:0] rd, input logic [`XLEN-1:0] data);
        wb_exp_s e;
        @(negedge clk_i);
        tick = tick + 32'd1;
        check_outputs();
        instr_valid_i = v;
        instr_i       = instr;
        pc_i          = cur_pc;
        e.valid = exp_v;
        e.rd    = rd;
        e.data  = data;
        e.tick  = tick;
        exp_q.push_back(e);
        if (exp_v && rd != '0) model_regs[rd] = data;    // model updated at issue
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic bubble(input logic v, input logic [31:0] instr);
        drive(v, instr, 1'b0, '0, '0);
    endtask

    task automatic issue_reg(input logic [2:0] f3, input logic alt,
                             input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        drive(1'b1, r_type(alt ? 7'h20 : 7'h00, f3, rd, rs1, rs2), 1'b1, rd,
              alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic issue_imm(input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [11:0] imm);
        drive(1'b1, i_type(f3, rd, rs1, imm), 1'b1, rd,
              alu_ref(f3, 1'b0, model_regs[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic issue_shift(input logic [2:0] f3, input logic alt,
                               input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] shamt);
        drive(1'b1, shift_imm(alt ? 7'h20 : 7'h00, f3, rd, rs1, shamt), 1'b1, rd,
              alu_ref(f3, alt, model_regs[rs1], {27'd0, shamt}));
    endtask

    task automatic issue_upper(input logic auipc, input logic [4:0] rd, input logic [19:0] imm);
        drive(1'b1, upper_type(auipc ? OPC_AUIPC_T : OPC_LUI_T, rd, imm), 1'b1, rd,
              {imm, 12'd0} + (auipc ? cur_pc : 32'd0));
    endtask

    // idle cycles until every expected writeback has been compared
    task automatic drain();
        while (pending_valid()) begin
            bubble(1'b0, 32'd0);
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        drain();
        if (errors == errs_before) begin
            $display("test %0d %s: pass", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
            tests_failed++;
        end
    endtask

    task automatic test_reset_state();
        repeat (4) bubble(1'b0, 32'd0);
        for (int k = 1; k < `REG_COUNT; k++) begin
            issue_reg(3'b110, 1'b0, 5'(k), 5'(k), 5'(k));    // or of xk with itself reads zero
        end
    endtask

    task automatic test_reg_alu();
        logic [31:0] r;
        logic [3:0]  op;
        for (int k = 1; k < `REG_COUNT; k++) begin
            r = $urandom();
            issue_upper(1'b0, 5'(k), r[31:12]);
            issue_imm(3'b000, 5'(k), 5'(k), r[11:0]);
        end
        issue_upper(1'b0, 5'd1, 20'h80000);
        issue_imm(3'b000, 5'd1, 5'd1, 12'hfff);    // x1 = 7fffffff
        issue_upper(1'b0, 5'd2, 20'h80000);
        issue_imm(3'b000, 5'd3, 5'd0, 12'hfff);
        issue_imm(3'b000, 5'd4, 5'd0, 12'h001);
        issue_reg(3'b010, 1'b0, 5'd16, 5'd1, 5'd2);
        issue_reg(3'b011, 1'b0, 5'd16, 5'd1, 5'd2);
        issue_reg(3'b010, 1'b0, 5'd16, 5'd2, 5'd1);
        issue_reg(3'b011, 1'b0, 5'd16, 5'd2, 5'd1);
        issue_reg(3'b010, 1'b0, 5'd16, 5'd2, 5'd3);
        issue_reg(3'b011, 1'b0, 5'd16, 5'd2, 5'd3);
        issue_reg(3'b010, 1'b0, 5'd16, 5'd3, 5'd4);
        issue_reg(3'b011, 1'b0, 5'd16, 5'd3, 5'd4);
        for (int i = 0; i < 120; i++) begin
            op = r_op(i % 10);
            issue_reg(op[3:1], op[0], 5'($urandom_range(31, 16)),
                      5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));
            if ($urandom_range(1, 0) == 1) bubble(1'b0, $urandom());
        end
    endtask

    task automatic test_imm_alu();
        logic [31:0]      r;
        logic [11:0]      imm;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        for (int i = 0; i < 88; i++) begin
            r   = $urandom();
            imm = r[11:0];
            if (i % 2 == 0) imm[11] = 1'b1;    // negative immediate
            rd  = 5'($urandom_range(31, 16));
            rs1 = 5'($urandom_range(31, 1));
            case (i % 11)
                0: issue_imm(3'b000, rd, rs1, imm);
                1: issue_imm(3'b010, rd, rs1, imm);
                2: issue_imm(3'b011, rd, rs1, imm);
                3: issue_imm(3'b100, rd, rs1, imm);
                4: issue_imm(3'b110, rd, rs1, imm);
                5: issue_imm(3'b111, rd, rs1, imm);
                6: issue_shift(3'b001, 1'b0, rd, rs1, r[24:20]);
                7: issue_shift(3'b101, 1'b0, rd, rs1, r[24:20]);
                8: issue_shift(3'b101, 1'b1, rd, rs1, r[24:20]);
                9: issue_upper(1'b0, rd, r[31:12]);
                default: begin
                    cur_pc = $urandom() & 32'hffff_fffc;
                    issue_upper(1'b1, rd, r[31:12]);
                end
            endcase
        end
    endtask

    // each instruction reads the register written d instructions earlier
    task automatic test_dependency();
        logic [4:0] rg;
        for (int d = 1; d <= 3; d++) begin
            for (int j = 0; j < 12; j++) begin
                rg = 5'(8 + j % d);
                case (j % 4)
                    0: issue_reg(3'b000, 1'b0, rg, rg, 5'd14);
                    1: issue_imm(3'b000, rg, rg, 12'h123);
                    2: issue_reg(3'b000, 1'b1, rg, 5'd14, rg);
                    default: issue_reg(3'b000, 1'b0, rg, rg, rg);
                endcase
            end
        end
    endtask

    task automatic test_x0_writes();
        for (int i = 0; i < 4; i++) begin
            issue_imm(3'b000, 5'd0, 5'd1, 12'($urandom()));
            issue_reg(3'b000, 1'b0, 5'd20, 5'd0, 5'd0);    // right behind the x0 write
            issue_reg(3'b000, 1'b0, 5'd0, 5'd2, 5'd3);
            issue_reg(3'b110, 1'b0, 5'd21, 5'd0, 5'd2);
        end
    endtask

    task automatic test_bubbles();
        logic [31:0] bad;
        for (int i = 0; i < 10; i++) begin
            case (i % 5)
                0: bad = r_type(7'h01, 3'b000, 5'd9, 5'd9, 5'd9);
                1: bad = shift_imm(7'h01, 3'b001, 5'd9, 5'd9, 5'd1);
                2: bad = 32'd0;
                3: bad = {12'h004, 5'd9, 3'b010, 5'd9, 7'b0000011};    // load
                default: bad = {$urandom() | 32'h0000_007f};
            endcase
            issue_imm(3'b000, 5'd9, 5'd9, 12'h011);
            bubble(1'b1, bad);
            bubble(1'b0, i_type(3'b000, 5'd9, 5'd0, 12'h7ff));
            issue_reg(3'b000, 1'b0, 5'd22, 5'd9, 5'd9);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int start;
        void'($urandom(32'h2900));
        rst_i         = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        pc_i          = '0;
        tick          = '0;
        cur_pc        = 32'h0000_1000;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        for (int k = 0; k < `REG_COUNT; k++) begin
            model_regs[k] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        start = errors;
        test_reset_state();
        finish_test(1, "reset state", start);
        start = errors;
        test_reg_alu();
        finish_test(2, "register alu", start);
        start = errors;
        test_imm_alu();
        finish_test(3, "immediate alu", start);
        start = errors;
        test_dependency();
        finish_test(4, "dependency chains", start);
        start = errors;
        test_x0_writes();
        finish_test(5, "x0 writes", start);
        start = errors;
        test_bubbles();
        finish_test(6, "bubbles and invalid encodings", start);

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/core_macros.svh */
// core width parameters for the rv32i integer pipeline
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path and pc width
`define XLEN 32

// architectural register file
`define REG_AW    5
`define REG_COUNT 32

`endif

/* hw/core_pkg.sv */
// shared opcode, micro-operation and stage types of the integer pipeline
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [4:0] {
        UOP_INVALID,
        UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR,          // register alu
        UOP_SLT, UOP_SLTU, UOP_SLL, UOP_SRL, UOP_SRA,
        UOP_ADDI, UOP_ANDI, UOP_ORI, UOP_XORI,                // immediate alu
        UOP_SLTI, UOP_SLTIU, UOP_SLLI, UOP_SRLI, UOP_SRAI,
        UOP_LUI, UOP_AUIPC                                    // upper immediate
    } uop_e;

    // where an operand comes from
    typedef enum logic [1:0] {
        FWD_REG  = 2'd0,
        FWD_EXEC = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic               valid;
        uop_e               uop;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   op_a;
        logic [`XLEN-1:0]   op_b;
    } dec_ex_s;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_s;

endpackage

`default_nettype wire

/* hw/decode_regread.sv */
// decode and register read stage, builds operands and the execute micro-op
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module decode_regread import core_pkg::*; (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire [`XLEN-1:0]     instr_i,
    input  wire                 instr_valid_i,
    input  wire [`XLEN-1:0]     pc_i,
    output logic [`REG_AW-1:0]  rs1_o,
    output logic [`REG_AW-1:0]  rs2_o,
    input  wire [`XLEN-1:0]     rf_a_i,
    input  wire [`XLEN-1:0]     rf_b_i,
    input  wire fwd_sel_e       fwd_a_i,
    input  wire fwd_sel_e       fwd_b_i,
    input  wire wb_s            exec_i,
    input  wire wb_s            wb_i,
    output dec_ex_s             dec_ex_o
);

    logic [6:0]       funct7;
    logic [2:0]       funct3;
    uop_e             uop;
    logic [`XLEN-1:0] imm;
    logic             use_rs2;       // op_b from a register, not the immediate
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    dec_ex_s          dec_next;

    function automatic logic [`XLEN-1:0] fwd_value(input fwd_sel_e sel,
                                                   input logic [`XLEN-1:0] rf,
                                                   input wb_s exec,
                                                   input wb_s wb);
        logic [`XLEN-1:0] val;
        case (sel)
            FWD_EXEC: val = exec.data;
            FWD_WB:   val = wb.data;
            default:  val = rf;
        endcase
        return val;
    endfunction

    assign funct7 = instr_i[31:25];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    always_comb begin
        uop     = UOP_INVALID;
        imm     = '0;
        use_rs2 = 1'b0;
        case (opcode_e'(instr_i[6:0]))
            OPC_OP: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: uop = UOP_ADD;
                    {7'b0100000, 3'b000}: uop = UOP_SUB;
                    {7'b0000000, 3'b001}: uop = UOP_SLL;
                    {7'b0000000, 3'b010}: uop = UOP_SLT;
                    {7'b0000000, 3'b011}: uop = UOP_SLTU;
                    {7'b0000000, 3'b100}: uop = UOP_XOR;
                    {7'b0000000, 3'b101}: uop = UOP_SRL;
                    {7'b0100000, 3'b101}: uop = UOP_SRA;
                    {7'b0000000, 3'b110}: uop = UOP_OR;
                    {7'b0000000, 3'b111}: uop = UOP_AND;
                    default:              uop = UOP_INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                imm = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};    // sign extended
                case (funct3)
                    3'b000: uop = UOP_ADDI;
                    3'b010: uop = UOP_SLTI;
                    3'b011: uop = UOP_SLTIU;
                    3'b100: uop = UOP_XORI;
                    3'b110: uop = UOP_ORI;
                    3'b111: uop = UOP_ANDI;
                    3'b001: begin
                        imm = {{(`XLEN-5){1'b0}}, instr_i[24:20]};    // shamt only
                        if (funct7 == 7'b0000000) uop = UOP_SLLI;
                    end
                    default: begin
                        imm = {{(`XLEN-5){1'b0}}, instr_i[24:20]};
                        if (funct7 == 7'b0000000)      uop = UOP_SRLI;
                        else if (funct7 == 7'b0100000) uop = UOP_SRAI;
                    end
                endcase
            end
            OPC_LUI: begin
                uop = UOP_LUI;
                imm = {instr_i[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                uop = UOP_AUIPC;
                imm = {instr_i[31:12], 12'b0};
            end
            default: uop = UOP_INVALID;
        endcase
    end

    // forwarding only ever touches register operands
    assign src_a = fwd_value(fwd_a_i, rf_a_i, exec_i, wb_i);
    assign src_b = fwd_value(fwd_b_i, rf_b_i, exec_i, wb_i);

    always_comb begin
        dec_next.valid = instr_valid_i && (uop != UOP_INVALID);
        dec_next.uop   = uop;
        dec_next.rd    = instr_i[11:7];
        case (uop)
            UOP_LUI:   dec_next.op_a = '0;
            UOP_AUIPC: dec_next.op_a = pc_i;
            default:   dec_next.op_a = src_a;
        endcase
        dec_next.op_b  = use_rs2 ? src_b : imm;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_ex_o.valid <= 1'b0;
        end else begin
            dec_ex_o <= dec_next;    // bubble when invalid or no instruction
        end
    end

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
// execute stage ALU, result goes out for forwarding and into writeback
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module execute_unit import core_pkg::*; (
    input  wire            clk_i,
    input  wire            rst_i,
    input  wire dec_ex_s   dec_ex_i,
    output wb_s            exec_o,
    output wb_s            wb_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    assign op_a  = dec_ex_i.op_a;
    assign op_b  = dec_ex_i.op_b;
    assign shamt = op_b[4:0];    // shifts use the low five bits only

    always_comb begin
        case (dec_ex_i.uop)
            UOP_ADD, UOP_ADDI, UOP_LUI, UOP_AUIPC: begin
                result = op_a + op_b;            // lui has op_a zero, auipc has pc
            end
            UOP_SUB:           result = op_a - op_b;
            UOP_AND, UOP_ANDI: result = op_a & op_b;
            UOP_OR, UOP_ORI:   result = op_a | op_b;
            UOP_XOR, UOP_XORI: result = op_a ^ op_b;
            UOP_SLT, UOP_SLTI: begin
                result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            UOP_SLTU, UOP_SLTIU: begin
                result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            end
            UOP_SLL, UOP_SLLI: result = op_a << shamt;
            UOP_SRL, UOP_SRLI: result = op_a >> shamt;
            UOP_SRA, UOP_SRAI: result = $signed(op_a) >>> shamt;
            default:           result = '0;
        endcase
    end

    // combinational view for the decode stage bypass
    always_comb begin
        exec_o.valid = dec_ex_i.valid;
        exec_o.rd    = dec_ex_i.rd;
        exec_o.data  = result;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o <= exec_o;
        end
    end

endmodule

`default_nettype wire

/* hw/hazard_forward.sv */
// picks forwarding sources for both decode operands from execute and writeback
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module hazard_forward import core_pkg::*; (
    input  wire [`REG_AW-1:0] rs1_i,
    input  wire [`REG_AW-1:0] rs2_i,
    input  wire wb_s          exec_i,
    input  wire wb_s          wb_i,
    output fwd_sel_e          fwd_a_o,
    output fwd_sel_e          fwd_b_o
);

    // x0 never forwards, the younger instruction in execute wins
    function automatic fwd_sel_e pick_src(input logic [`REG_AW-1:0] rs,
                                          input wb_s exec,
                                          input wb_s wb);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (wb.valid && (wb.rd == rs) && (rs != '0)) begin
            sel = FWD_WB;
        end
        if (exec.valid && (exec.rd == rs) && (rs != '0)) begin
            sel = FWD_EXEC;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_src(rs1_i, exec_i, wb_i);
    assign fwd_b_o = pick_src(rs2_i, exec_i, wb_i);

endmodule

`default_nettype wire

/* hw/int_pipe_top.sv */
// top of the three stage rv32i integer pipeline
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module int_pipe_top import core_pkg::*; (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire [`XLEN-1:0]     instr_i,
    input  wire                 instr_valid_i,
    input  wire [`XLEN-1:0]     pc_i,
    output logic                wb_valid_o,
    output logic [`REG_AW-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]    wb_data_o
);

    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`XLEN-1:0]   rf_a;
    logic [`XLEN-1:0]   rf_b;
    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;
    dec_ex_s            dec_ex;
    wb_s                exec_fwd;    // result still in execute
    wb_s                wb;          // result being written this cycle

    decode_regread u_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rf_a_i        (rf_a),
        .rf_b_i        (rf_b),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .exec_i        (exec_fwd),
        .wb_i          (wb),
        .dec_ex_o      (dec_ex)
    );

    hazard_forward u_hazard (
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .exec_i  (exec_fwd),
        .wb_i    (wb),
        .fwd_a_o (fwd_a),
        .fwd_b_o (fwd_b)
    );

    execute_unit u_execute (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .dec_ex_i (dec_ex),
        .exec_o   (exec_fwd),
        .wb_o     (wb)
    );

    reg_file u_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_addr_a_i (rs1),
        .rd_addr_b_i (rs2),
        .rd_data_a_o (rf_a),
        .rd_data_b_o (rf_b),
        .wb_i        (wb)
    );

    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// integer register file, two read ports and one write port, x0 reads zero
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module reg_file import core_pkg::*; (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire [`REG_AW-1:0]       rd_addr_a_i,
    input  wire [`REG_AW-1:0]       rd_addr_b_i,
    output logic [`XLEN-1:0]        rd_data_a_o,
    output logic [`XLEN-1:0]        rd_data_b_o,
    input  wire wb_s                wb_i
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];    // no storage behind x0

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // reads see the old value during a write, the hazard unit covers that
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
+incdir+bench
hw/core_pkg.sv
hw/reg_file.sv
hw/hazard_forward.sv
hw/decode_regread.sv
hw/execute_unit.sv
hw/int_pipe_top.sv
bench/int_pipe_tb.sv

/* run.sh */
#!/bin/sh
# build and run the integer pipeline testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f list.f --top-module int_pipe_tb -o int_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/int_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
